// ==== arena_pkg.sv ====
package arena_pkg;

  // Game state widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  sprite_idx_t;
  typedef logic [2:0]  slot_t;

  localparam int NUM_REGS  = 32;
  localparam int NUM_SLOTS = 8; // Attributes per sprite

endpackage

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage (
  input  logic                   pixel_clk_in,
  input  logic                   rst_in,
  input  logic                   head_valid,
  input  isa_pkg::instr_t        head_data,
  input  arena_pkg::word_t       reg_a,
  input  arena_pkg::word_t       reg_b,
  input  arena_pkg::word_t       spr_a,
  input  arena_pkg::word_t       spr_b,
  input  logic                   can_accept,
  output logic                   pop,
  output arena_pkg::reg_idx_t    reg_rd_a,
  output arena_pkg::reg_idx_t    reg_rd_b,
  output arena_pkg::sprite_idx_t spr_rd_a,
  output arena_pkg::sprite_idx_t spr_rd_b,
  output arena_pkg::slot_t       slot_rd_a,
  output arena_pkg::slot_t       slot_rd_b,
  output logic                   r1_valid,
  output logic                   r1_is_sprite,
  output arena_pkg::reg_idx_t    r1_reg,
  output arena_pkg::sprite_idx_t r1_sprite,
  output arena_pkg::slot_t       r1_slot,
  output arena_pkg::word_t       r1_data
);

  isa_pkg::opcode_t opcode;
  logic             is_sub;
  logic             known;
  arena_pkg::word_t op_ra, op_rb, op_sa, op_sb;
  arena_pkg::word_t res_data;
  logic             res_is_sprite;

  function automatic arena_pkg::word_t sat_sub(arena_pkg::word_t a, arena_pkg::word_t b);
    return (a < b) ? '0 : a - b; // Floors at zero
  endfunction

  assign opcode = isa_pkg::opcode_t'({head_data[32], head_data[6:0]});
  assign is_sub = (head_data[isa_pkg::FUNCT_HI:isa_pkg::FUNCT_LO] == isa_pkg::FUNCT_SUB);

  assign reg_rd_a  = head_data[isa_pkg::RS1_HI:isa_pkg::RS1_LO];
  assign reg_rd_b  = head_data[isa_pkg::RS2_HI:isa_pkg::RS2_LO];
  assign spr_rd_a  = head_data[isa_pkg::SPD_HI:isa_pkg::SPD_LO]; // Sprite destination
  assign spr_rd_b  = head_data[isa_pkg::SPS_HI:isa_pkg::SPS_LO];
  assign slot_rd_a = (opcode == isa_pkg::OP_ATTACK) ?
                     head_data[isa_pkg::ATK_DST_HI:isa_pkg::ATK_DST_LO] :
                     head_data[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO];
  assign slot_rd_b = (opcode == isa_pkg::OP_ATTACK) ?
                     head_data[isa_pkg::ATK_SRC_HI:isa_pkg::ATK_SRC_LO] :
                     head_data[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO];

  // Bypass from R1 on a matching destination
  assign op_ra = (r1_valid && !r1_is_sprite && r1_reg == reg_rd_a) ? r1_data : reg_a;
  assign op_rb = (r1_valid && !r1_is_sprite && r1_reg == reg_rd_b) ? r1_data : reg_b;
  assign op_sa = (r1_valid && r1_is_sprite && r1_sprite == spr_rd_a && r1_slot == slot_rd_a) ?
                 r1_data : spr_a;
  assign op_sb = (r1_valid && r1_is_sprite && r1_sprite == spr_rd_b && r1_slot == slot_rd_b) ?
                 r1_data : spr_b;

  always_comb begin
    known         = 1'b1;
    res_is_sprite = 1'b0;
    res_data      = '0;
    case (opcode)
      isa_pkg::OP_LI:
        res_data = arena_pkg::word_t'(head_data[isa_pkg::LI_IMM_HI:isa_pkg::LI_IMM_LO]);
      isa_pkg::OP_ADDI:
        res_data = op_ra + arena_pkg::word_t'(head_data[isa_pkg::IMM12_HI:isa_pkg::IMM12_LO]);
      isa_pkg::OP_ALU:
        res_data = is_sub ? sat_sub(op_ra, op_rb) : op_ra + op_rb;
      isa_pkg::OP_SPLI: begin
        res_is_sprite = 1'b1;
        res_data = arena_pkg::word_t'(head_data[isa_pkg::SPLI_IMM_HI:isa_pkg::SPLI_IMM_LO]);
      end
      isa_pkg::OP_SPALU: begin
        res_is_sprite = 1'b1;
        res_data = is_sub ? sat_sub(op_sa, op_ra) : op_sa + op_ra;
      end
      isa_pkg::OP_LISP:
        res_data = op_sb;
      isa_pkg::OP_ATTACK: begin
        res_is_sprite = 1'b1;
        res_data = sat_sub(op_sa, op_sb); // Target slot minus attacker slot
      end
      default: known = 1'b0; // Dropped, no writeback
    endcase
  end

  assign pop = head_valid && (!r1_valid || can_accept);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      r1_valid <= 1'b0;
    end else if (pop) begin
      r1_valid <= known;
    end else if (can_accept) begin
      r1_valid <= 1'b0; // Item moved to writeback
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (pop && known) begin
      r1_is_sprite <= res_is_sprite;
      r1_reg       <= head_data[isa_pkg::RD_HI:isa_pkg::RD_LO];
      r1_sprite    <= spr_rd_a;
      r1_slot      <= slot_rd_a;
      r1_data      <= res_data;
    end
  end

  // A stalled result stays put until writeback takes it
  assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    (r1_valid && !can_accept) |=> (r1_valid && $stable(r1_data) && $stable(r1_is_sprite) &&
                                   $stable(r1_reg) && $stable(r1_sprite) && $stable(r1_slot)));

endmodule

// ==== instr_fifo.sv ====
`timescale 1ns/1ps

module instr_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic            pixel_clk_in,
  input  logic            rst_in,
  input  logic            instr_valid,
  input  isa_pkg::instr_t instr_data,
  input  logic            pop,
  output logic            head_valid,
  output isa_pkg::instr_t head_data,
  output logic            instr_credit
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  isa_pkg::instr_t  mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];

  always_ff @(posedge pixel_clk_in) begin
    if (instr_valid) begin
      mem[wr_ptr] <= instr_data;
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      instr_credit <= 1'b0;
    end else begin
      instr_credit <= pop; // One credit back per consumed word
      if (instr_valid) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({instr_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer must respect credits, consumer must respect head_valid
  assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    !(instr_valid && count == FULL_CNT));
  assert property (@(posedge pixel_clk_in) disable iff (rst_in) !(pop && !head_valid));

endmodule

// ==== isa_pkg.sv ====
package isa_pkg;

  typedef logic [35:0] instr_t;

  // {word[32], word[6:0]}
  typedef enum logic [7:0] {
    OP_LI     = 8'b0011_0111,
    OP_ADDI   = 8'b0001_0011,
    OP_ALU    = 8'b0011_0011, // ADD, SUB
    OP_SPLI   = 8'b1011_0111,
    OP_SPALU  = 8'b1011_0011, // SPADD, SPSUB
    OP_LISP   = 8'b1011_1111,
    OP_ATTACK = 8'b1011_1011
  } opcode_t;

  localparam int FUNCT_LO = 25;
  localparam int FUNCT_HI = 31;
  localparam logic [6:0] FUNCT_SUB = 7'b010_0000;

  localparam int RD_LO = 7;
  localparam int RD_HI = 11;
  localparam int SPD_LO = 7;
  localparam int SPD_HI = 12;
  localparam int RS1_LO = 15;
  localparam int RS1_HI = 19;
  localparam int RS2_LO = 20;
  localparam int RS2_HI = 24;
  localparam int SPS_LO = 14;
  localparam int SPS_HI = 19;
  localparam int SLOT_LO = 33;
  localparam int SLOT_HI = 35;
  localparam int ATK_DST_LO = 29;
  localparam int ATK_DST_HI = 31;
  localparam int ATK_SRC_LO = 26;
  localparam int ATK_SRC_HI = 28;
  localparam int IMM12_LO = 20;
  localparam int IMM12_HI = 31;
  localparam int LI_IMM_LO = 12;
  localparam int LI_IMM_HI = 31;
  localparam int SPLI_IMM_LO = 13;
  localparam int SPLI_IMM_HI = 31;

endpackage

// ==== operand_file.sv ====
`timescale 1ns/1ps

module operand_file #(
  parameter int NUM_SPRITES = 64
) (
  input  logic                   pixel_clk_in,
  input  logic                   rst_in,
  input  arena_pkg::reg_idx_t    reg_rd_a,
  input  arena_pkg::reg_idx_t    reg_rd_b,
  input  arena_pkg::sprite_idx_t spr_rd_a,
  input  arena_pkg::sprite_idx_t spr_rd_b,
  input  arena_pkg::slot_t       slot_rd_a,
  input  arena_pkg::slot_t       slot_rd_b,
  input  logic                   wr_en,
  input  logic                   wr_is_sprite,
  input  arena_pkg::reg_idx_t    wr_reg,
  input  arena_pkg::sprite_idx_t wr_sprite,
  input  arena_pkg::slot_t       wr_slot,
  input  arena_pkg::word_t       wr_data,
  output arena_pkg::word_t       reg_a,
  output arena_pkg::word_t       reg_b,
  output arena_pkg::word_t       spr_a,
  output arena_pkg::word_t       spr_b
);

  arena_pkg::word_t regs [arena_pkg::NUM_REGS];
  arena_pkg::word_t sprites [NUM_SPRITES][arena_pkg::NUM_SLOTS];

  assign reg_a = regs[reg_rd_a];
  assign reg_b = regs[reg_rd_b];
  assign spr_a = sprites[spr_rd_a][slot_rd_a];
  assign spr_b = sprites[spr_rd_b][slot_rd_b];

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin // New game, everything zero
      for (int i = 0; i < arena_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      for (int s = 0; s < NUM_SPRITES; s++) begin
        for (int k = 0; k < arena_pkg::NUM_SLOTS; k++) begin
          sprites[s][k] <= '0;
        end
      end
    end else if (wr_en) begin
      if (wr_is_sprite) begin
        sprites[wr_sprite][wr_slot] <= wr_data;
      end else begin
        regs[wr_reg] <= wr_data;
      end
    end
  end

endmodule

// ==== processor_top.sv ====
`timescale 1ns/1ps

module processor_top #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2,
  parameter int NUM_SPRITES = 64
) (
  input  logic                   pixel_clk_in,
  input  logic                   rst_in,
  input  logic                   instr_valid,
  input  isa_pkg::instr_t        instr_data,
  output logic                   instr_credit,
  output logic                   wb_valid,
  output logic                   wb_is_sprite,
  output arena_pkg::reg_idx_t    wb_reg,
  output arena_pkg::sprite_idx_t wb_sprite,
  output arena_pkg::slot_t       wb_slot,
  output arena_pkg::word_t       wb_data,
  input  logic                   wb_credit
);

  logic                   head_valid;
  isa_pkg::instr_t        head_data;
  logic                   pop;
  arena_pkg::reg_idx_t    reg_rd_a, reg_rd_b;
  arena_pkg::sprite_idx_t spr_rd_a, spr_rd_b;
  arena_pkg::slot_t       slot_rd_a, slot_rd_b;
  arena_pkg::word_t       reg_a, reg_b, spr_a, spr_b;
  logic                   r1_valid, r1_is_sprite;
  arena_pkg::reg_idx_t    r1_reg;
  arena_pkg::sprite_idx_t r1_sprite;
  arena_pkg::slot_t       r1_slot;
  arena_pkg::word_t       r1_data;
  logic                   can_accept;
  logic                   wr_en;

  assign wr_en = r1_valid && can_accept; // R1 retires into the state files

  instr_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instr_fifo_inst (
    .pixel_clk_in, .rst_in, .instr_valid, .instr_data, .pop,
    .head_valid, .head_data, .instr_credit
  );

  operand_file #(.NUM_SPRITES(NUM_SPRITES)) operand_file_inst (
    .pixel_clk_in, .rst_in, .reg_rd_a, .reg_rd_b, .spr_rd_a, .spr_rd_b,
    .slot_rd_a, .slot_rd_b, .wr_en, .wr_is_sprite(r1_is_sprite), .wr_reg(r1_reg),
    .wr_sprite(r1_sprite), .wr_slot(r1_slot), .wr_data(r1_data),
    .reg_a, .reg_b, .spr_a, .spr_b
  );

  exec_stage exec_stage_inst (
    .pixel_clk_in, .rst_in, .head_valid, .head_data, .reg_a, .reg_b, .spr_a, .spr_b,
    .can_accept, .pop, .reg_rd_a, .reg_rd_b, .spr_rd_a, .spr_rd_b, .slot_rd_a, .slot_rd_b,
    .r1_valid, .r1_is_sprite, .r1_reg, .r1_sprite, .r1_slot, .r1_data
  );

  wb_output #(.OUT_CREDITS(OUT_CREDITS)) wb_output_inst (
    .pixel_clk_in, .rst_in, .r1_valid, .r1_is_sprite, .r1_reg, .r1_sprite, .r1_slot,
    .r1_data, .wb_credit, .can_accept, .wb_valid, .wb_is_sprite, .wb_reg, .wb_sprite,
    .wb_slot, .wb_data
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_processor -o sim_processor -f verilog.f

./obj_dir/sim_processor | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure"
  exit 1
fi

// ==== tb_processor.sv ====
`timescale 1ns/1ps

module tb_processor;

  localparam int FIFO_DEPTH  = 4;
  localparam int OUT_CREDITS = 2;
  localparam int N_RANDOM    = 200;
  localparam int NUM_INSTR   = 240; // Upper bound over all phases
  localparam int WORST_CYC   = 16;
  localparam longint LIMIT_NS = longint'(NUM_INSTR * WORST_CYC + 600) * 8;

  typedef struct packed {
    logic             is_sprite;
    logic [5:0]       idx;
    arena_pkg::slot_t slot;
    arena_pkg::word_t data;
  } wb_event_t;

  logic                   pixel_clk_in = 1'b0;
  logic                   rst_in = 1'b1;
  logic                   instr_valid = 1'b0;
  isa_pkg::instr_t        instr_data = '0;
  logic                   wb_credit = 1'b0;
  logic                   instr_credit, wb_valid, wb_is_sprite;
  arena_pkg::reg_idx_t    wb_reg;
  arena_pkg::sprite_idx_t wb_sprite;
  arena_pkg::slot_t       wb_slot;
  arena_pkg::word_t       wb_data;

  logic [31:0]      lfsr = 32'h1393_f345;
  arena_pkg::word_t m_regs [32] = '{default: '0};
  arena_pkg::word_t m_spr [64][8] = '{default: '{default: '0}};
  wb_event_t        exp_q [$];
  logic [7:0]       op_list [8] = '{isa_pkg::OP_LI, isa_pkg::OP_ADDI, isa_pkg::OP_ALU,
                                    isa_pkg::OP_SPLI, isa_pkg::OP_SPALU, isa_pkg::OP_LISP,
                                    isa_pkg::OP_ATTACK, 8'h7f};
  int   credits = FIFO_DEPTH;
  int   sent = 0;
  int   credit_pulses = 0;
  int   held = 0; // Writebacks not yet returned as credit
  int   wb_events = 0;
  int   value_errors = 0;
  int   other_errors = 0;
  logic withhold = 1'b0;
  logic random_stall = 1'b0;

  processor_top #(.FIFO_DEPTH(FIFO_DEPTH), .OUT_CREDITS(OUT_CREDITS), .NUM_SPRITES(64))
    processor_top_inst (.*);

  always #4 pixel_clk_in = ~pixel_clk_in;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [5:0] pick_idx();
    return (rand_bits(2) == 32'd0) ? 6'(rand_bits(6)) : 6'(rand_bits(2)); // Mostly a small pool
  endfunction

  function automatic arena_pkg::word_t floor_sub(input arena_pkg::word_t a,
                                                 input arena_pkg::word_t b);
    return (a >= b) ? a - b : 32'd0;
  endfunction

  function automatic wb_event_t make_event(input logic spr, input logic [5:0] idx,
                                           input arena_pkg::slot_t slot,
                                           input arena_pkg::word_t data);
    wb_event_t e;
    e.is_sprite = spr;
    e.idx       = idx;
    e.slot      = slot;
    e.data      = data;
    return e;
  endfunction

  function automatic isa_pkg::instr_t encode(input logic [7:0] opc, input logic sub,
      input logic [5:0] dst, input logic [5:0] src_a, input logic [4:0] src_b,
      input arena_pkg::slot_t slot_a, input arena_pkg::slot_t slot_b, input logic [19:0] imm);
    isa_pkg::instr_t w;
    w      = '0;
    w[32]  = opc[7];
    w[6:0] = opc[6:0];
    case (opc)
      isa_pkg::OP_LI: begin
        w[isa_pkg::RD_HI:isa_pkg::RD_LO]         = dst[4:0];
        w[isa_pkg::LI_IMM_HI:isa_pkg::LI_IMM_LO] = imm;
      end
      isa_pkg::OP_ADDI: begin
        w[isa_pkg::RD_HI:isa_pkg::RD_LO]       = dst[4:0];
        w[isa_pkg::RS1_HI:isa_pkg::RS1_LO]     = src_a[4:0];
        w[isa_pkg::IMM12_HI:isa_pkg::IMM12_LO] = imm[11:0];
      end
      isa_pkg::OP_ALU: begin
        w[isa_pkg::RD_HI:isa_pkg::RD_LO]       = dst[4:0];
        w[isa_pkg::RS1_HI:isa_pkg::RS1_LO]     = src_a[4:0];
        w[isa_pkg::RS2_HI:isa_pkg::RS2_LO]     = src_b;
        w[isa_pkg::FUNCT_HI:isa_pkg::FUNCT_LO] = sub ? isa_pkg::FUNCT_SUB : 7'd0;
      end
      isa_pkg::OP_SPLI: begin
        w[isa_pkg::SPD_HI:isa_pkg::SPD_LO]           = dst;
        w[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO]         = slot_a;
        w[isa_pkg::SPLI_IMM_HI:isa_pkg::SPLI_IMM_LO] = imm[18:0];
      end
      isa_pkg::OP_SPALU: begin
        w[isa_pkg::SPD_HI:isa_pkg::SPD_LO]     = dst;
        w[isa_pkg::RS1_HI:isa_pkg::RS1_LO]     = src_a[4:0];
        w[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO]   = slot_a;
        w[isa_pkg::FUNCT_HI:isa_pkg::FUNCT_LO] = sub ? isa_pkg::FUNCT_SUB : 7'd0;
      end
      isa_pkg::OP_LISP: begin
        w[isa_pkg::RD_HI:isa_pkg::RD_LO]     = dst[4:0];
        w[isa_pkg::SPS_HI:isa_pkg::SPS_LO]   = src_a;
        w[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO] = slot_a;
      end
      isa_pkg::OP_ATTACK: begin
        w[isa_pkg::SPD_HI:isa_pkg::SPD_LO]         = dst;   // Target sprite
        w[isa_pkg::SPS_HI:isa_pkg::SPS_LO]         = src_a; // Attacker
        w[isa_pkg::ATK_DST_HI:isa_pkg::ATK_DST_LO] = slot_a;
        w[isa_pkg::ATK_SRC_HI:isa_pkg::ATK_SRC_LO] = slot_b;
      end
      default: w = w;
    endcase
    return w;
  endfunction

  task automatic value_fail(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    value_errors++;
    $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  task automatic note_fail(input string msg);
    other_errors++;
    $display("%0t: %s", $time, msg);
  endtask

  // One clock of producer and consumer bookkeeping
  task automatic step();
    @(posedge pixel_clk_in);
    #1;
    instr_valid = 1'b0;
    if (instr_credit) begin
      credits++;
      credit_pulses++;
    end
    if (wb_valid) begin
      held++;
    end
    wb_credit = 1'b0;
    if (held > 0 && !withhold && (!random_stall || rand_bits(1) == 32'd1)) begin
      wb_credit = 1'b1;
      held--;
    end
  endtask

  task automatic send(input isa_pkg::instr_t w);
    logic [7:0]             opc;
    logic                   sub;
    arena_pkg::reg_idx_t    rd, rs1, rs2;
    arena_pkg::sprite_idx_t spd, sps;
    arena_pkg::slot_t       slot, adst, asrc;
    arena_pkg::word_t       cur;
    wb_event_t              e;
    logic                   known;
    opc   = {w[32], w[6:0]};
    sub   = (w[isa_pkg::FUNCT_HI:isa_pkg::FUNCT_LO] == isa_pkg::FUNCT_SUB);
    rd    = w[isa_pkg::RD_HI:isa_pkg::RD_LO];
    rs1   = w[isa_pkg::RS1_HI:isa_pkg::RS1_LO];
    rs2   = w[isa_pkg::RS2_HI:isa_pkg::RS2_LO];
    spd   = w[isa_pkg::SPD_HI:isa_pkg::SPD_LO];
    sps   = w[isa_pkg::SPS_HI:isa_pkg::SPS_LO];
    slot  = w[isa_pkg::SLOT_HI:isa_pkg::SLOT_LO];
    adst  = w[isa_pkg::ATK_DST_HI:isa_pkg::ATK_DST_LO];
    asrc  = w[isa_pkg::ATK_SRC_HI:isa_pkg::ATK_SRC_LO];
    cur   = m_spr[spd][slot];
    known = 1'b1;
    e     = '0;
    case (opc)
      isa_pkg::OP_LI:
        e = make_event(1'b0, {1'b0, rd}, 3'd0, 32'(w[isa_pkg::LI_IMM_HI:isa_pkg::LI_IMM_LO]));
      isa_pkg::OP_ADDI:
        e = make_event(1'b0, {1'b0, rd}, 3'd0,
                       m_regs[rs1] + 32'(w[isa_pkg::IMM12_HI:isa_pkg::IMM12_LO]));
      isa_pkg::OP_ALU:
        e = make_event(1'b0, {1'b0, rd}, 3'd0, sub ? floor_sub(m_regs[rs1], m_regs[rs2]) :
                                                     m_regs[rs1] + m_regs[rs2]);
      isa_pkg::OP_SPLI:
        e = make_event(1'b1, spd, slot, 32'(w[isa_pkg::SPLI_IMM_HI:isa_pkg::SPLI_IMM_LO]));
      isa_pkg::OP_SPALU:
        e = make_event(1'b1, spd, slot, sub ? floor_sub(cur, m_regs[rs1]) : cur + m_regs[rs1]);
      isa_pkg::OP_LISP:
        e = make_event(1'b0, {1'b0, rd}, 3'd0, m_spr[sps][slot]);
      isa_pkg::OP_ATTACK:
        e = make_event(1'b1, spd, adst, floor_sub(m_spr[spd][adst], m_spr[sps][asrc]));
      default: known = 1'b0;
    endcase
    if (known) begin
      if (e.is_sprite) begin
        m_spr[e.idx][e.slot] = e.data;
      end else begin
        m_regs[e.idx[4:0]] = e.data;
      end
      exp_q.push_back(e);
    end
    while (credits == 0) begin
      step();
    end
    instr_data  = w;
    instr_valid = 1'b1;
    credits--;
    sent++;
    step();
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0 || credit_pulses != sent || held != 0) && n < 500) begin
      step();
      n++;
    end
    assert (exp_q.size() == 0) else note_fail("expected writebacks never arrived");
    assert (credit_pulses == sent) else note_fail("instruction credits were not all returned");
  endtask

  always @(negedge pixel_clk_in) begin
    wb_event_t e;
    if (!rst_in && wb_valid) begin
      wb_events++;
      if (exp_q.size() == 0) begin
        note_fail("writeback event arrived with nothing expected");
      end else begin
        e = exp_q.pop_front();
        assert (wb_is_sprite == e.is_sprite)
          else value_fail("wb_is_sprite", 32'(e.is_sprite), 32'(wb_is_sprite));
        if (e.is_sprite) begin
          assert (wb_sprite == e.idx) else value_fail("wb_sprite", 32'(e.idx), 32'(wb_sprite));
          assert (wb_slot == e.slot) else value_fail("wb_slot", 32'(e.slot), 32'(wb_slot));
        end else begin
          assert (wb_reg == e.idx[4:0]) else value_fail("wb_reg", 32'(e.idx), 32'(wb_reg));
        end
        assert (wb_data == e.data) else value_fail("wb_data", e.data, wb_data);
      end
    end
  end

  assert property (@(posedge pixel_clk_in) disable iff (rst_in) held <= OUT_CREDITS)
    else note_fail("more writebacks delivered than output credits allow");
  assert property (@(posedge pixel_clk_in) disable iff (rst_in) credits <= FIFO_DEPTH)
    else note_fail("instruction credit returned that was never spent");

  initial begin
    #(LIMIT_NS);
    $display("watchdog expired at %0t before the tests finished", $time);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int         base;
    logic [7:0] opc;
    repeat (5) @(posedge pixel_clk_in);
    #1;
    rst_in = 1'b0;
    // Register ops with each result feeding the next
    send(encode(isa_pkg::OP_LI, 1'b0, 6'd1, 6'd0, 5'd0, 3'd0, 3'd0, 20'h00123));
    send(encode(isa_pkg::OP_LI, 1'b0, 6'd2, 6'd0, 5'd0, 3'd0, 3'd0, 20'h00456));
    send(encode(isa_pkg::OP_ALU, 1'b0, 6'd3, 6'd1, 5'd2, 3'd0, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_ALU, 1'b1, 6'd4, 6'd1, 5'd2, 3'd0, 3'd0, 20'd0)); // Floors at 0
    send(encode(isa_pkg::OP_ALU, 1'b1, 6'd5, 6'd3, 5'd1, 3'd0, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_ADDI, 1'b0, 6'd5, 6'd5, 5'd0, 3'd0, 3'd0, 20'h00fff));
    drain();
    // Sprite ops
    send(encode(isa_pkg::OP_SPLI, 1'b0, 6'd5, 6'd0, 5'd0, 3'd2, 3'd0, 20'd100));
    send(encode(isa_pkg::OP_SPLI, 1'b0, 6'd6, 6'd0, 5'd0, 3'd1, 3'd0, 20'd150));
    send(encode(isa_pkg::OP_SPALU, 1'b0, 6'd5, 6'd1, 5'd0, 3'd2, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_SPALU, 1'b1, 6'd5, 6'd1, 5'd0, 3'd2, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_SPALU, 1'b1, 6'd7, 6'd1, 5'd0, 3'd0, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_LISP, 1'b0, 6'd7, 6'd5, 5'd0, 3'd2, 3'd0, 20'd0));
    send(encode(isa_pkg::OP_ATTACK, 1'b0, 6'd5, 6'd6, 5'd0, 3'd2, 3'd1, 20'd0)); // Overkill
    send(encode(isa_pkg::OP_SPLI, 1'b0, 6'd5, 6'd0, 5'd0, 3'd3, 3'd0, 20'd500));
    send(encode(isa_pkg::OP_ATTACK, 1'b0, 6'd5, 6'd6, 5'd0, 3'd3, 3'd1, 20'd0));
    send(encode(isa_pkg::OP_LISP, 1'b0, 6'd8, 6'd5, 5'd0, 3'd3, 3'd0, 20'd0));
    drain();
    // Unknown opcode is consumed silently
    base = wb_events;
    send(encode(8'h7f, 1'b0, 6'd9, 6'd1, 5'd2, 3'd0, 3'd0, 20'h12345));
    drain();
    repeat (4) step(); // Window in which a wrong writeback would show
    assert (wb_events == base) else note_fail("unknown opcode produced a writeback");
    // Output stall with chained ADDI
    withhold = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send(encode(isa_pkg::OP_ADDI, 1'b0, 6'd8, 6'd8, 5'd0, 3'd0, 3'd0, 20'h00011));
    end
    repeat (20) step();
    assert (held == OUT_CREDITS) else note_fail("stalled output did not use exactly its credits");
    assert (exp_q.size() == 6 - OUT_CREDITS) else note_fail("events lost during output stall");
    withhold = 1'b0;
    drain();
    // Random mix with a randomly slow consumer
    random_stall = 1'b1;
    for (int i = 0; i < N_RANDOM; i++) begin
      opc = op_list[3'(rand_bits(3))];
      send(encode(opc, rand_bits(1) == 32'd1, pick_idx(), pick_idx(), 5'(pick_idx()),
                  3'(rand_bits(2)), 3'(rand_bits(2)), 20'(rand_bits(20))));
    end
    drain();
    repeat (4) step();
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
isa_pkg.sv
arena_pkg.sv
instr_fifo.sv
operand_file.sv
exec_stage.sv
wb_output.sv
processor_top.sv
tb_processor.sv

// ==== wb_output.sv ====
`timescale 1ns/1ps

module wb_output #(
  parameter int OUT_CREDITS = 2
) (
  input  logic                   pixel_clk_in,
  input  logic                   rst_in,
  input  logic                   r1_valid,
  input  logic                   r1_is_sprite,
  input  arena_pkg::reg_idx_t    r1_reg,
  input  arena_pkg::sprite_idx_t r1_sprite,
  input  arena_pkg::slot_t       r1_slot,
  input  arena_pkg::word_t       r1_data,
  input  logic                   wb_credit,
  output logic                   can_accept,
  output logic                   wb_valid,
  output logic                   wb_is_sprite,
  output arena_pkg::reg_idx_t    wb_reg,
  output arena_pkg::sprite_idx_t wb_sprite,
  output arena_pkg::slot_t       wb_slot,
  output arena_pkg::word_t       wb_data
);

  localparam int CNT_W = $clog2(OUT_CREDITS + 1);
  localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(OUT_CREDITS);

  logic [CNT_W-1:0] credits;
  logic             advance;

  assign can_accept = (credits != '0);
  assign advance    = r1_valid && can_accept;

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      credits  <= MAX_CREDITS;
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= advance; // Single-cycle event
      case ({advance, wb_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (advance) begin
      wb_is_sprite <= r1_is_sprite;
      wb_reg       <= r1_reg;
      wb_sprite    <= r1_sprite;
      wb_slot      <= r1_slot;
      wb_data      <= r1_data;
    end
  end

  // Consumer returns only what it was given
  assert property (@(posedge pixel_clk_in) disable iff (rst_in) credits <= MAX_CREDITS);

endmodule
